// File: lsu_bus_intf.sv
`timescale 1ns/1ps

module lsu_bus_intf #(
  parameter int num_stbuf = 4
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  lsu_pkg::lsu_req_t          req_m,
  input  logic                       coalesce_disable,
  input  logic                       wr_done,
  output logic [lsu_pkg::data_w-1:0] bus_read_data_m,
  output logic                       ld_full_hit_m,
  output logic                       wr_valid,
  output lsu_pkg::stbuf_entry_t      wr_entry,
  output logic                       stbuf_full,
  output logic                       stbuf_empty
);

  lsu_pkg::lsu_lanes_t        lanes_m, lanes_r;
  lsu_pkg::lsu_req_t          req_r;
  logic [lsu_pkg::data_w-1:0] data_lo_r, data_hi_r;
  lsu_pkg::lsu_fwd_t          rpipe_lo, rpipe_hi;
  lsu_pkg::lsu_fwd_t          buf_lo, buf_hi;

  // ************************************************************
  // m stage
  // ************************************************************
  lsu_byte_lanes m_lanes_i (
    .addr  (req_m.addr),
    .size  (req_m.size),
    .lanes (lanes_m)
  );

  lsu_r_stage r_stage_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_m     (req_m),
    .req_r     (req_r),
    .lanes_r   (lanes_r),
    .data_lo_r (data_lo_r),
    .data_hi_r (data_hi_r)
  );

  lsu_rpipe_fwd rpipe_fwd_i (
    .req_m     (req_m),
    .req_r     (req_r),
    .lanes_m   (lanes_m),
    .lanes_r   (lanes_r),
    .data_lo_r (data_lo_r),
    .data_hi_r (data_hi_r),
    .rpipe_lo  (rpipe_lo),
    .rpipe_hi  (rpipe_hi)
  );

  lsu_store_buf #(
    .num_stbuf (num_stbuf)
  ) store_buf_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .req_r            (req_r),
    .lanes_r          (lanes_r),
    .data_lo_r        (data_lo_r),
    .data_hi_r        (data_hi_r),
    .coalesce_disable (coalesce_disable),
    .lanes_m          (lanes_m),
    .wr_done          (wr_done),
    .buf_lo           (buf_lo),
    .buf_hi           (buf_hi),
    .wr_valid         (wr_valid),
    .stbuf_full       (stbuf_full),
    .stbuf_empty      (stbuf_empty),
    .wr_entry         (wr_entry)
  );

  lsu_fwd_merge fwd_merge_i (
    .req_m           (req_m),
    .lanes_m         (lanes_m),
    .rpipe_lo        (rpipe_lo),
    .rpipe_hi        (rpipe_hi),
    .buf_lo          (buf_lo),
    .buf_hi          (buf_hi),
    .bus_read_data_m (bus_read_data_m),
    .ld_full_hit_m   (ld_full_hit_m)
  );

endmodule

// File: lsu_bus_intf_asserts.sv
`timescale 1ns/1ps

module lsu_bus_intf_asserts (
  input logic              clk,
  input logic              arst_n,
  input lsu_pkg::lsu_req_t req_m,
  input logic              ld_full_hit_m,
  input logic              wr_valid,
  input logic              stbuf_full,
  input logic              stbuf_empty
);

  // a full hit only means something for a plain load
  full_hit_is_load: assert property (@(posedge clk) disable iff (!arst_n)
    ld_full_hit_m |-> (req_m.valid && req_m.load && !req_m.sideeffect))
    else $error("full hit without a valid non side-effect load");

  not_full_and_empty: assert property (@(posedge clk) disable iff (!arst_n)
    !(stbuf_full && stbuf_empty))
    else $error("store buffer full and empty at once");

  valid_tracks_empty: assert property (@(posedge clk) disable iff (!arst_n)
    wr_valid == !stbuf_empty)  // drain valid whenever anything is held
    else $error("wr_valid disagrees with stbuf_empty");

endmodule

bind lsu_bus_intf lsu_bus_intf_asserts asserts_i (
  .clk           (clk),
  .arst_n        (arst_n),
  .req_m         (req_m),
  .ld_full_hit_m (ld_full_hit_m),
  .wr_valid      (wr_valid),
  .stbuf_full    (stbuf_full),
  .stbuf_empty   (stbuf_empty)
);

// File: lsu_bus_intf_tb.sv
`timescale 1ns/1ps

module lsu_bus_intf_tb;

  localparam int num_stbuf  = 4;
  localparam int test_len   = 40;                       // steps in the longest test
  localparam int max_cycles = 3 + 6 * test_len + 20;    // reset, six tests, margin

  logic                       clk = 1'b0;
  logic                       arst_n;
  lsu_pkg::lsu_req_t          req_m;
  logic                       coalesce_disable;
  logic                       wr_done;
  logic [lsu_pkg::data_w-1:0] bus_read_data_m;
  logic                       ld_full_hit_m;
  logic                       wr_valid;
  lsu_pkg::stbuf_entry_t      wr_entry;
  logic                       stbuf_full;
  logic                       stbuf_empty;

  lsu_pkg::stbuf_entry_t model_q[$];      // buffer contents, oldest first
  lsu_pkg::lsu_req_t     m_q;             // request at m
  lsu_pkg::lsu_req_t     r_q;             // request at r
  logic                  pop_q;
  logic                  coal_dis_q;
  logic                  coal_dis_next;
  logic [31:0]           rng = 32'h27402c8d;
  int                    errors = 0;

  lsu_bus_intf #(
    .num_stbuf (num_stbuf)
  ) dut_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .req_m            (req_m),
    .coalesce_disable (coalesce_disable),
    .wr_done          (wr_done),
    .bus_read_data_m  (bus_read_data_m),
    .ld_full_hit_m    (ld_full_hit_m),
    .wr_valid         (wr_valid),
    .wr_entry         (wr_entry),
    .stbuf_full       (stbuf_full),
    .stbuf_empty      (stbuf_empty)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] rand_base();
    return next_rand() & 32'hffff_fff0;  // room for a few words without wrapping
  endfunction

  function automatic int size_bytes(input lsu_pkg::lsu_size_e s);
    case (s)
      lsu_pkg::size_byte: return 1;
      lsu_pkg::size_half: return 2;
      default:            return 4;
    endcase
  endfunction

  function automatic lsu_pkg::lsu_req_t make_req(input logic ld, input logic st,
      input logic se, input lsu_pkg::lsu_size_e sz, input logic [31:0] addr,
      input logic [31:0] data);
    lsu_pkg::lsu_req_t rq;
    rq            = '0;
    rq.valid      = ld | st;
    rq.load       = ld;
    rq.store      = st;
    rq.sideeffect = se;
    rq.size       = sz;
    rq.addr       = addr;
    rq.data       = data;
    return rq;
  endfunction

  function automatic lsu_pkg::lsu_req_t idle_req();
    return make_req(1'b0, 1'b0, 1'b0, lsu_pkg::size_byte, '0, '0);
  endfunction

  function automatic lsu_pkg::lsu_req_t load_req(input lsu_pkg::lsu_size_e sz,
      input logic [31:0] addr, input logic se);
    return make_req(1'b1, 1'b0, se, sz, addr, '0);
  endfunction

  function automatic lsu_pkg::lsu_req_t store_req(input lsu_pkg::lsu_size_e sz,
      input logic [31:0] addr, input logic [31:0] data);
    return make_req(1'b0, 1'b1, 1'b0, sz, addr, data);
  endfunction

  task automatic report_mismatch(input string name, input logic [67:0] got,
      input logic [67:0] exp);
    errors++;
    $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
  endtask

  // ************************************************************
  // reference model
  // ************************************************************
  // an r store lands word by word, merged into the youngest entry when allowed
  task automatic model_write(input lsu_pkg::lsu_req_t st);
    lsu_pkg::stbuf_entry_t part [2];
    lsu_pkg::stbuf_entry_t e;
    logic [31:0]           a;
    int                    lane;
    int                    young;
    part[0]      = '0;
    part[1]      = '0;
    part[0].word = st.addr[31:2];
    for (int i = 0; i < size_bytes(st.size); i++) begin
      a    = st.addr + i;
      lane = (a[31:2] == st.addr[31:2]) ? 0 : 1;
      part[lane].word                = a[31:2];
      part[lane].byteen[a[1:0]]      = 1'b1;
      part[lane].data[8*a[1:0] +: 8] = st.data[8*i +: 8];
    end
    young = model_q.size() - 1;  // youngest before this store
    for (int l = 0; l < 2; l++) begin
      if (l == 0 || part[1].byteen != '0) begin
        if (!coal_dis_q && young >= 0 && model_q[young].word == part[l].word) begin
          e = model_q[young];
          for (int b = 0; b < 4; b++) begin
            if (part[l].byteen[b]) begin
              e.byteen[b]       = 1'b1;
              e.data[8*b +: 8]  = part[l].data[8*b +: 8];
            end
          end
          model_q[young] = e;
        end else begin
          model_q.push_back(part[l]);
        end
      end
    end
  endtask

  task automatic check_load(input lsu_pkg::lsu_req_t ld);
    logic [31:0] a;
    logic [31:0] off;
    logic [31:0] exp_d;
    logic [31:0] mask;
    logic        all_hit;
    logic        found;
    all_hit = 1'b1;
    exp_d   = '0;
    mask    = '0;
    for (int i = 0; i < size_bytes(ld.size); i++) begin
      a     = ld.addr + i;
      found = 1'b0;
      foreach (model_q[k]) begin
        if (model_q[k].word == a[31:2] && model_q[k].byteen[a[1:0]]) begin
          found           = 1'b1;
          exp_d[8*i +: 8] = model_q[k].data[8*a[1:0] +: 8];
        end
      end
      off = a - r_q.addr;
      if (r_q.valid && r_q.store && off < size_bytes(r_q.size)) begin  // r store is youngest
        found           = 1'b1;
        exp_d[8*i +: 8] = r_q.data[8*off +: 8];
      end
      mask[8*i +: 8] = 8'hff;
      all_hit        = all_hit & found;
    end
    all_hit = all_hit & ~ld.sideeffect;
    if (ld_full_hit_m !== all_hit) report_mismatch("ld_full_hit_m", ld_full_hit_m, all_hit);
    if (all_hit && (bus_read_data_m & mask) !== exp_d) begin
      report_mismatch("bus_read_data_m", bus_read_data_m & mask, exp_d);
    end
  endtask

  task automatic check_status();
    logic [31:0] mask;
    if (wr_valid !== (model_q.size() != 0)) begin
      report_mismatch("wr_valid", wr_valid, model_q.size() != 0);
    end
    if (stbuf_empty !== (model_q.size() == 0)) begin
      report_mismatch("stbuf_empty", stbuf_empty, model_q.size() == 0);
    end
    if (stbuf_full !== ((num_stbuf - model_q.size()) < 2)) begin
      report_mismatch("stbuf_full", stbuf_full, (num_stbuf - model_q.size()) < 2);
    end
    if (model_q.size() != 0) begin
      for (int b = 0; b < 4; b++) mask[8*b +: 8] = {8{model_q[0].byteen[b]}};
      if (wr_entry.word !== model_q[0].word) begin
        report_mismatch("wr_entry.word", wr_entry.word, model_q[0].word);
      end
      if (wr_entry.byteen !== model_q[0].byteen) begin
        report_mismatch("wr_entry.byteen", wr_entry.byteen, model_q[0].byteen);
      end
      if ((wr_entry.data & mask) !== (model_q[0].data & mask)) begin
        report_mismatch("wr_entry.data", wr_entry.data & mask, model_q[0].data & mask);
      end
    end
  endtask

  // one clock: the edge retires pop and r store, then the new request goes to m
  task automatic step(input lsu_pkg::lsu_req_t rq, input logic pop);
    @(posedge clk);
    if (pop_q && model_q.size() != 0) model_q.delete(0);
    if (r_q.valid && r_q.store) model_write(r_q);
    r_q              = m_q;
    m_q              = rq;
    pop_q            = pop;
    coal_dis_q       = coal_dis_next;
    req_m            <= rq;
    wr_done          <= pop;
    coalesce_disable <= coal_dis_next;
    @(negedge clk);                            // outputs settled
    check_status();
    if (rq.valid && rq.load) begin
      check_load(rq);
    end else if (ld_full_hit_m !== 1'b0) begin
      report_mismatch("ld_full_hit_m", ld_full_hit_m, 1'b0);
    end
  endtask

  task automatic drain();
    repeat (2) step(idle_req(), 1'b0);         // stores in flight reach the buffer
    for (int i = 0; i < 2 * num_stbuf && wr_valid; i++) step(idle_req(), 1'b1);
    step(idle_req(), 1'b0);
    if (!stbuf_empty) begin
      errors++;
      $display("store buffer still holds entries after draining");
    end
  endtask

  // ************************************************************
  // directed tests
  // ************************************************************
  task automatic reset_state();
    step(load_req(lsu_pkg::size_word, next_rand() & ~32'h3, 1'b0), 1'b0);
    if (!stbuf_empty || wr_valid || ld_full_hit_m) begin
      errors++;
      $display("buffer not empty or load hit right after reset");
    end
  endtask

  task automatic rpipe_then_buffer();
    logic [31:0] base;
    logic [31:0] d;
    base = rand_base();
    d    = next_rand();
    step(store_req(lsu_pkg::size_word, base, d), 1'b0);
    step(load_req(lsu_pkg::size_word, base, 1'b0), 1'b0);  // store sits at r
    if (bus_read_data_m !== d) report_mismatch("bus_read_data_m", bus_read_data_m, d);
    step(load_req(lsu_pkg::size_word, base, 1'b0), 1'b0);  // now in the buffer
    drain();
  endtask

  task automatic partial_overlap();
    logic [31:0] base;
    logic [31:0] d;
    base = rand_base();
    d    = next_rand();
    step(store_req(lsu_pkg::size_half, base + 1, d), 1'b0);
    step(load_req(lsu_pkg::size_byte, base + 2, 1'b0), 1'b0);
    if (bus_read_data_m[7:0] !== d[15:8]) begin
      report_mismatch("bus_read_data_m", bus_read_data_m[7:0], d[15:8]);
    end
    drain();
    step(store_req(lsu_pkg::size_byte, base + 3, d), 1'b0);
    step(idle_req(), 1'b0);
    step(load_req(lsu_pkg::size_word, base, 1'b0), 1'b0);  // one of four bytes known
    step(store_req(lsu_pkg::size_word, base + 4, d), 1'b0);
    step(idle_req(), 1'b0);
    step(load_req(lsu_pkg::size_word, base + 4, 1'b1), 1'b0);  // side-effect
    drain();
  endtask

  task automatic crossing_store();
    logic [31:0] base;
    logic [31:0] d;
    base = rand_base();
    d    = next_rand();
    step(store_req(lsu_pkg::size_word, base + 2, d), 1'b0);
    step(load_req(lsu_pkg::size_half, base + 3, 1'b0), 1'b0);  // both lanes from r
    if (bus_read_data_m[15:0] !== d[23:8]) begin
      report_mismatch("bus_read_data_m", bus_read_data_m[15:0], d[23:8]);
    end
    step(load_req(lsu_pkg::size_word, base + 2, 1'b0), 1'b0);  // both lanes from buffer
    if (wr_entry.byteen !== 4'b1100) report_mismatch("wr_entry.byteen", wr_entry.byteen, 4'hc);
    drain();
  endtask

  task automatic coalescing();
    logic [31:0] base;
    logic [31:0] d;
    base = rand_base();
    d    = next_rand();
    for (int dis = 0; dis < 2; dis++) begin
      coal_dis_next = dis[0];
      step(store_req(lsu_pkg::size_byte, base, d), 1'b0);
      step(store_req(lsu_pkg::size_byte, base + 2, d >> 8), 1'b0);
      repeat (2) step(idle_req(), 1'b0);
      if (dis == 0 && wr_entry.byteen !== 4'b0101) begin
        report_mismatch("wr_entry.byteen", wr_entry.byteen, 4'b0101);
      end
      if (dis == 1 && wr_entry.byteen !== 4'b0001) begin
        report_mismatch("wr_entry.byteen", wr_entry.byteen, 4'b0001);
      end
      drain();
    end
    coal_dis_next = 1'b0;
  endtask

  task automatic fill_and_drain();
    logic [31:0] base;
    base = rand_base();
    for (int k = 0; k < 2 * num_stbuf && !stbuf_full; k++) begin
      step(store_req(lsu_pkg::size_word, base + 4 * k, next_rand()), 1'b0);
      repeat (2) step(idle_req(), 1'b0);       // full flag reflects this store
    end
    if (!stbuf_full) begin
      errors++;
      $display("store buffer never reported full");
    end
    drain();
  endtask

  initial begin
    arst_n           = 1'b0;
    req_m            = '0;
    wr_done          = 1'b0;
    coalesce_disable = 1'b0;
    m_q              = '0;
    r_q              = '0;
    pop_q            = 1'b0;
    coal_dis_q       = 1'b0;
    coal_dis_next    = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    reset_state();
    rpipe_then_buffer();
    partial_overlap();
    crossing_store();
    coalescing();
    fill_and_drain();
    $display("summary: %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(max_cycles * 100);
    $display("watchdog: run did not finish within %0d cycles", max_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

// File: lsu_byte_lanes.sv
`timescale 1ns/1ps

module lsu_byte_lanes (
  input  logic [lsu_pkg::addr_w-1:0] addr,
  input  lsu_pkg::lsu_size_e         size,
  output lsu_pkg::lsu_lanes_t        lanes
);

  logic [lsu_pkg::num_bytes-1:0]   byteen;
  logic [2*lsu_pkg::num_bytes-1:0] byteen_ext;  // 8-byte window over two words
  logic [1:0]                      end_off;     // bytes minus one
  logic [lsu_pkg::addr_w-1:0]      end_addr;

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        byteen  = 4'b0001;
        end_off = 2'd0;
      end
      lsu_pkg::size_half: begin
        byteen  = 4'b0011;
        end_off = 2'd1;
      end
      default: begin
        byteen  = 4'b1111;
        end_off = 2'd3;
      end
    endcase
  end

  assign byteen_ext = {4'b0, byteen} << addr[1:0];
  assign end_addr   = addr + {30'b0, end_off};

  assign lanes.word_lo   = addr[lsu_pkg::addr_w-1:2];
  assign lanes.word_hi   = end_addr[lsu_pkg::addr_w-1:2];
  assign lanes.byteen_lo = byteen_ext[3:0];
  assign lanes.byteen_hi = byteen_ext[7:4];

endmodule

// File: lsu_fwd_merge.sv
`timescale 1ns/1ps

module lsu_fwd_merge (
  input  lsu_pkg::lsu_req_t          req_m,
  input  lsu_pkg::lsu_lanes_t        lanes_m,
  input  lsu_pkg::lsu_fwd_t          rpipe_lo,
  input  lsu_pkg::lsu_fwd_t          rpipe_hi,
  input  lsu_pkg::lsu_fwd_t          buf_lo,
  input  lsu_pkg::lsu_fwd_t          buf_hi,
  output logic [lsu_pkg::data_w-1:0] bus_read_data_m,
  output logic                       ld_full_hit_m
);

  lsu_pkg::lsu_fwd_t            fwd_lo, fwd_hi;
  logic                         full_lo, full_hi;
  logic [2*lsu_pkg::data_w-1:0] fwd_shift;

  // r pipe is younger than anything in the buffer, so it wins per byte
  function automatic lsu_pkg::lsu_fwd_t pick(
    input lsu_pkg::lsu_fwd_t rp,
    input lsu_pkg::lsu_fwd_t bf
  );
    pick.hit = rp.hit | bf.hit;
    for (int b = 0; b < lsu_pkg::num_bytes; b++) begin
      pick.data[8*b +: 8] = rp.hit[b] ? rp.data[8*b +: 8] : bf.data[8*b +: 8];
    end
  endfunction

  always_comb begin
    fwd_lo = pick(rpipe_lo, buf_lo);
    fwd_hi = pick(rpipe_hi, buf_hi);
  end

  // every byte the load needs must be covered
  assign full_lo = &(fwd_lo.hit | ~lanes_m.byteen_lo);
  assign full_hi = &(fwd_hi.hit | ~lanes_m.byteen_hi);

  assign ld_full_hit_m = full_lo & full_hi & req_m.valid & req_m.load & ~req_m.sideeffect;

  // back into load order
  assign fwd_shift       = {fwd_hi.data, fwd_lo.data} >> {req_m.addr[1:0], 3'b0};
  assign bus_read_data_m = fwd_shift[lsu_pkg::data_w-1:0];

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

  localparam int addr_w    = 32;
  localparam int data_w    = 32;
  localparam int num_bytes = 4;  // bytes per word lane

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } lsu_size_e;

  // ************************************************************
  // request and lane views
  // ************************************************************
  typedef struct packed {
    logic                valid;
    logic                load;
    logic                store;
    logic                sideeffect;
    lsu_size_e           size;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   data;   // store data, unaligned
  } lsu_req_t;

  typedef struct packed {
    logic [addr_w-3:0]    word_lo;    // word holding the start byte
    logic [addr_w-3:0]    word_hi;    // word holding the end byte
    logic [num_bytes-1:0] byteen_lo;
    logic [num_bytes-1:0] byteen_hi;  // zero unless the access crosses a word
  } lsu_lanes_t;

  typedef struct packed {
    logic [addr_w-3:0]    word;
    logic [num_bytes-1:0] byteen;
    logic [data_w-1:0]    data;
  } stbuf_entry_t;

  // one lane of forwarding answer
  typedef struct packed {
    logic [num_bytes-1:0] hit;
    logic [data_w-1:0]    data;
  } lsu_fwd_t;

endpackage

// File: lsu_r_stage.sv
`timescale 1ns/1ps

module lsu_r_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  lsu_pkg::lsu_req_t          req_m,
  output lsu_pkg::lsu_req_t          req_r,
  output lsu_pkg::lsu_lanes_t        lanes_r,
  output logic [lsu_pkg::data_w-1:0] data_lo_r,
  output logic [lsu_pkg::data_w-1:0] data_hi_r
);

  logic                         valid_q;
  lsu_pkg::lsu_req_t            req_q;      // payload, valid bit taken from valid_q
  logic [2*lsu_pkg::data_w-1:0] data_ext;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_m.valid;
    end
  end

  always_ff @(posedge clk) begin
    req_q <= req_m;
  end

  always_comb begin
    req_r       = req_q;
    req_r.valid = valid_q;
  end

  // lane view of the registered access
  lsu_byte_lanes r_lanes_i (
    .addr  (req_q.addr),
    .size  (req_q.size),
    .lanes (lanes_r)
  );

  // store data lined up with its byte enables
  assign data_ext  = {32'b0, req_q.data} << {req_q.addr[1:0], 3'b0};
  assign data_lo_r = data_ext[lsu_pkg::data_w-1:0];
  assign data_hi_r = data_ext[2*lsu_pkg::data_w-1:lsu_pkg::data_w];

endmodule

// File: lsu_rpipe_fwd.sv
`timescale 1ns/1ps

module lsu_rpipe_fwd (
  input  lsu_pkg::lsu_req_t          req_m,
  input  lsu_pkg::lsu_req_t          req_r,
  input  lsu_pkg::lsu_lanes_t        lanes_m,
  input  lsu_pkg::lsu_lanes_t        lanes_r,
  input  logic [lsu_pkg::data_w-1:0] data_lo_r,
  input  logic [lsu_pkg::data_w-1:0] data_hi_r,
  output lsu_pkg::lsu_fwd_t          rpipe_lo,
  output lsu_pkg::lsu_fwd_t          rpipe_hi
);

  logic ld_st_pair;  // load at m with a live store at r

  assign ld_st_pair = req_m.valid & req_m.load & req_r.valid & req_r.store;

  // ************************************************************
  // one m lane against both r lanes
  // ************************************************************
  function automatic lsu_pkg::lsu_fwd_t lane_fwd(
    input logic                          en,
    input logic [lsu_pkg::addr_w-3:0]    m_word,
    input logic [lsu_pkg::num_bytes-1:0] m_byteen,
    input lsu_pkg::lsu_lanes_t           r_lanes,
    input logic [lsu_pkg::data_w-1:0]    r_lo,
    input logic [lsu_pkg::data_w-1:0]    r_hi
  );
    logic                          match_lo;
    logic                          match_hi;
    logic [lsu_pkg::num_bytes-1:0] hit_lo;
    logic [lsu_pkg::num_bytes-1:0] hit_hi;
    match_lo = en & (m_word == r_lanes.word_lo);
    match_hi = en & (m_word == r_lanes.word_hi);
    hit_lo   = {4{match_lo}} & r_lanes.byteen_lo & m_byteen;
    hit_hi   = {4{match_hi}} & r_lanes.byteen_hi & m_byteen;
    lane_fwd.hit = hit_lo | hit_hi;
    for (int b = 0; b < lsu_pkg::num_bytes; b++) begin
      lane_fwd.data[8*b +: 8] = ({8{hit_lo[b]}} & r_lo[8*b +: 8]) |
                                ({8{hit_hi[b]}} & r_hi[8*b +: 8]);
    end
  endfunction

  always_comb begin
    rpipe_lo = lane_fwd(ld_st_pair, lanes_m.word_lo, lanes_m.byteen_lo,
                        lanes_r, data_lo_r, data_hi_r);
    rpipe_hi = lane_fwd(ld_st_pair, lanes_m.word_hi, lanes_m.byteen_hi,
                        lanes_r, data_lo_r, data_hi_r);
  end

endmodule

// File: lsu_store_buf.sv
`timescale 1ns/1ps

module lsu_store_buf #(
  parameter int num_stbuf = 4
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  lsu_pkg::lsu_req_t          req_r,
  input  lsu_pkg::lsu_lanes_t        lanes_r,
  input  logic [lsu_pkg::data_w-1:0] data_lo_r,
  input  logic [lsu_pkg::data_w-1:0] data_hi_r,
  input  logic                       coalesce_disable,
  input  lsu_pkg::lsu_lanes_t        lanes_m,
  input  logic                       wr_done,
  output lsu_pkg::lsu_fwd_t          buf_lo,
  output lsu_pkg::lsu_fwd_t          buf_hi,
  output logic                       wr_valid,
  output logic                       stbuf_full,
  output logic                       stbuf_empty,
  output lsu_pkg::stbuf_entry_t      wr_entry
);

  localparam int ptr_w = (num_stbuf > 1) ? $clog2(num_stbuf) : 1;
  localparam int cnt_w = $clog2(num_stbuf + 1);

  lsu_pkg::stbuf_entry_t entries [num_stbuf];
  logic [ptr_w-1:0]      wr_ptr;
  logic [ptr_w-1:0]      rd_ptr;
  logic [cnt_w-1:0]      count;
  logic [ptr_w-1:0]      young_idx;
  logic                  store_r, has_young, pop;
  logic                  merge_lo, merge_hi, push_lo, push_hi;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    ptr_inc = (p == ptr_w'(num_stbuf - 1)) ? '0 : p + 1'b1;
  endfunction

  // byte-wise overlay of new store bytes onto an entry
  function automatic lsu_pkg::stbuf_entry_t merge_bytes(
    input lsu_pkg::stbuf_entry_t         e,
    input logic [lsu_pkg::num_bytes-1:0] be,
    input logic [lsu_pkg::data_w-1:0]    d
  );
    merge_bytes = e;
    for (int b = 0; b < lsu_pkg::num_bytes; b++) begin
      if (be[b]) begin
        merge_bytes.byteen[b]       = 1'b1;
        merge_bytes.data[8*b +: 8]  = d[8*b +: 8];
      end
    end
  endfunction

  // ************************************************************
  // write side and coalescing
  // ************************************************************
  assign store_r   = req_r.valid & req_r.store;
  assign pop       = wr_done & (count != '0);   // pop on empty is dropped
  assign young_idx = (wr_ptr == '0) ? ptr_w'(num_stbuf - 1) : wr_ptr - 1'b1;
  assign has_young = count > cnt_w'(pop);       // youngest must survive this cycle's pop

  assign merge_lo = store_r & ~coalesce_disable & has_young &
                    (lanes_r.word_lo == entries[young_idx].word);
  assign merge_hi = store_r & ~coalesce_disable & has_young & (|lanes_r.byteen_hi) &
                    (lanes_r.word_hi == entries[young_idx].word);
  assign push_lo  = store_r & ~merge_lo;
  assign push_hi  = store_r & (|lanes_r.byteen_hi) & ~merge_hi;

  always_ff @(posedge clk) begin
    if (merge_lo) entries[young_idx] <= merge_bytes(entries[young_idx], lanes_r.byteen_lo, data_lo_r);
    if (merge_hi) entries[young_idx] <= merge_bytes(entries[young_idx], lanes_r.byteen_hi, data_hi_r);
    if (push_lo) begin
      entries[wr_ptr] <= merge_bytes('{word: lanes_r.word_lo, byteen: '0, data: '0},
                                     lanes_r.byteen_lo, data_lo_r);
    end
    if (push_hi) begin
      entries[push_lo ? ptr_inc(wr_ptr) : wr_ptr] <=
        merge_bytes('{word: lanes_r.word_hi, byteen: '0, data: '0},
                    lanes_r.byteen_hi, data_hi_r);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_lo && push_hi) wr_ptr <= ptr_inc(ptr_inc(wr_ptr));
      else if (push_lo || push_hi) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + cnt_w'(push_lo) + cnt_w'(push_hi) - cnt_w'(pop);
    end
  end

  assign stbuf_empty = (count == '0);
  assign stbuf_full  = (int'(count) + 2) > num_stbuf;  // room for a crossing store
  assign wr_valid    = ~stbuf_empty;
  assign wr_entry    = entries[rd_ptr];                // oldest

  // ************************************************************
  // lookup, oldest first so younger bytes overwrite
  // ************************************************************
  always_comb begin
    logic [ptr_w-1:0] idx;
    idx    = rd_ptr;
    buf_lo = '0;
    buf_hi = '0;
    for (int k = 0; k < num_stbuf; k++) begin
      if (k < int'(count)) begin
        for (int b = 0; b < lsu_pkg::num_bytes; b++) begin
          if (entries[idx].byteen[b] && lanes_m.byteen_lo[b] &&
              entries[idx].word == lanes_m.word_lo) begin
            buf_lo.hit[b]          = 1'b1;
            buf_lo.data[8*b +: 8]  = entries[idx].data[8*b +: 8];
          end
          if (entries[idx].byteen[b] && lanes_m.byteen_hi[b] &&
              entries[idx].word == lanes_m.word_hi) begin
            buf_hi.hit[b]          = 1'b1;
            buf_hi.data[8*b +: 8]  = entries[idx].data[8*b +: 8];
          end
        end
      end
      idx = ptr_inc(idx);
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module lsu_bus_intf_tb -f vlog.f -o lsu_sim
./obj_dir/lsu_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED"
  exit 1
fi

// File: vlog.f
lsu_pkg.sv
lsu_byte_lanes.sv
lsu_r_stage.sv
lsu_rpipe_fwd.sv
lsu_store_buf.sv
lsu_fwd_merge.sv
lsu_bus_intf.sv
lsu_bus_intf_asserts.sv
lsu_bus_intf_tb.sv
